//--- song_rom.hex
// One word per line: note code in bits 11:6, duration in beats in bits 5:0.
// Songs 0 to 3 follow each other, 32 words per song.
342
3C1
441
482
002
501
581
600
643
601
581
502
481
441
3C1
343
941
9C1
A42
001
C41
CC1
D42
FC1
042
0C1
141
202
301
001
642
344
641
6C2
741
782
801
882
901
942
001
941
902
881
802
781
742
6C1
642
341
382
401
002
B01
B82
C01
F02
F41
F82
081
1C2
281
2C0
643
942
001
941
B02
B01
B82
B81
B03
A81
A81
A41
A41
9C1
9C1
943
001
501
501
481
481
441
441
3C2
000
341
641
941
C41
F41
FC2
E01
044
341
381
3C1
401
441
481
4C1
501
541
581
5C1
601
641
681
6C1
701
741
781
7C1
801
841
881
8C1
901
941
981
9C1
A01
A41
A81
AC1
B01

//--- sim.f
music_pkg.sv
synth_pkg.sv
song_rom.sv
song_reader.sv
note_player.sv
square_synth.sv
music_player.sv
tb_music_player.sv

//--- Makefile
TOP = tb_music_player

run:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module music_player

clean:
	rm -rf obj_dir

.PHONY: run lint clean

//--- tb_music_player.sv
`default_nettype none
`timescale 1ns/1ps

// Directed testbench for the tone sequencer.
// All outputs are sampled on the falling edge, and cycle counts are taken there.
module tb_music_player import music_pkg::*, synth_pkg::*;;

    // Number of notes that all tests play together. It sizes the run limit.
    localparam int NOTES_PLAYED = 80;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      play;
    song_sel_t song;
    note_t     note;
    duration_t duration;
    logic      new_note;
    logic      note_done;
    logic      song_done;
    logic      audio;

    // Reference copy of the song image.
    rom_word_t   model [0:ROM_DEPTH-1];
    logic [31:0] lfsr_state;
    song_sel_t   cur_song;
    note_idx_t   cur_idx;
    int          mismatches;
    int          failures;
    int          max_beats;
    int          cycles = 0;
    int          timeout_cycles = 100000;

    music_player dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song      (song),
        .note      (note),
        .duration  (duration),
        .new_note  (new_note),
        .note_done (note_done),
        .song_done (song_done),
        .audio     (audio)
    );

    always #4 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Galois LFSR that is stepped once for each bit taken.
    function automatic int take_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = value * 2 + int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return value;
    endfunction

    // Half period of a pitch code.
    // The octave is (code-1)/12 and the semitone is (code-1)%12.
    function automatic half_period_t expected_half(input note_t code);
        int steps;
        steps = (code == 6'd0) ? 0 : int'(code) - 1;
        return SEMITONE_HALF[steps % 12] >> (steps / 12);
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: %s is %0b, expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_note(input string name, input note_t got, input note_t exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_duration(input string name, input duration_t got, input duration_t exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_half(input string name, input half_period_t got,
                              input half_period_t exp);
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        play  <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        cur_idx = '0;
    endtask

    // Follows one note from the cycle that starts it (play seen or note_done seen).
    // new_note is due two cycles later and note_done max(dur,1)*BEAT_CYCLES after that.
    // A pause stretches the note by its length.
    task automatic run_note(input int pause_at, input int pause_len, input bit stop_at_end);
        rom_word_t    word;
        int           beats;
        int           total;
        int           last_edge;
        logic         prev_audio;
        half_period_t half;
        word       = model[{cur_song, cur_idx}];
        beats      = (word[5:0] == 6'd0) ? 1 : int'(word[5:0]);
        total      = beats * int'(BEAT_CYCLES) + pause_len;
        half       = expected_half(word[11:6]);
        last_edge  = 1;
        prev_audio = 1'b0;
        @(negedge clk);
        check_bit("new_note", new_note, 1'b0);
        check_bit("audio", audio, 1'b0);
        @(negedge clk);
        check_bit("new_note", new_note, 1'b1);
        check_note("note", note, word[11:6]);
        check_duration("duration", duration, word[5:0]);
        check_bit("audio", audio, 1'b0);
        for (int k = 1; k <= total; k++) begin
            if (pause_len > 0 && k == pause_at + 1) begin
                @(posedge clk);
                play <= 1'b0;
            end
            if (pause_len > 0 && k == pause_at + pause_len + 1) begin
                @(posedge clk);
                play <= 1'b1;
            end
            // Play drops on the edge that ends the note, so the reader sees it low.
            if (stop_at_end && k == total) begin
                @(posedge clk);
                play <= 1'b0;
            end
            @(negedge clk);
            check_bit("new_note", new_note, 1'b0);
            check_bit("note_done", note_done, k == total);
            check_bit("song_done", song_done, k == total && cur_idx == LAST_NOTE);
            // Sounding rises one cycle after new_note, and each half period flips audio.
            if (k == total || word[11:6] == 6'd0) begin
                check_bit("audio", audio, 1'b0);
            end else if (audio != prev_audio) begin
                check_half("audio half period", half_period_t'(k - last_edge), half);
                last_edge = k;
            end else if (k - last_edge == int'(half)) begin
                failures = failures + 1;
                $display("At %0t audio did not toggle %0d cycles after its last edge",
                         $time, half);
                last_edge = k;
            end
            prev_audio = audio;
        end
        if (!stop_at_end) begin
            cur_idx = cur_idx + 5'd1;
        end
    endtask

    // Outputs stay at 0 after reset while play is low.
    task automatic check_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_note("note", note, '0);
            check_duration("duration", duration, '0);
            check_bit("new_note", new_note, 1'b0);
            check_bit("note_done", note_done, 1'b0);
            check_bit("song_done", song_done, 1'b0);
            check_bit("audio", audio, 1'b0);
        end
    endtask

    // Twelve notes of a random song with play held high.
    task automatic check_song_notes();
        song_sel_t pick;
        pick = song_sel_t'(take_bits(2));
        cur_song = pick;
        @(posedge clk);
        song <= pick;
        play <= 1'b1;
        @(negedge clk);
        repeat (12) run_note(0, 0, 1'b0);
    endtask

    // A pause inside a note is followed by a stop at a note's end and a resume.
    task automatic check_pause();
        rom_word_t word;
        int        beats;
        int        pause_at;
        int        pause_len;
        word      = model[{cur_song, cur_idx}];
        beats     = (word[5:0] == 6'd0) ? 1 : int'(word[5:0]);
        pause_at  = 1 + take_bits(4) % (beats * int'(BEAT_CYCLES) - 2);
        pause_len = 1 + take_bits(4);
        run_note(pause_at, pause_len, 1'b0);
        run_note(0, 0, 1'b1);
        // The reader is idle now and must not start another note.
        repeat (12) begin
            @(negedge clk);
            check_bit("new_note", new_note, 1'b0);
            check_bit("note_done", note_done, 1'b0);
            check_bit("audio", audio, 1'b0);
        end
        @(posedge clk);
        play <= 1'b1;
        @(negedge clk);
        run_note(0, 0, 1'b1);
    endtask

    // Song 3 from the start.
    // song_done pulses on the 32nd note and the data for index 0 follows.
    task automatic check_song_wrap();
        apply_reset();
        cur_song = 2'd3;
        @(posedge clk);
        song <= 2'd3;
        play <= 1'b1;
        @(negedge clk);
        repeat (32) run_note(0, 0, 1'b0);
        run_note(0, 0, 1'b1);
    endtask

    // Song 0 covers rests, a zero duration and the highest octave.
    // A pause on note 22 keeps its short tone running for several half periods.
    task automatic check_audio_tones();
        cur_song = 2'd0;
        @(posedge clk);
        song <= 2'd0;
        play <= 1'b1;
        @(negedge clk);
        repeat (22) run_note(0, 0, 1'b0);
        run_note(2, 12, 1'b0);
        repeat (8) run_note(0, 0, 1'b0);
        run_note(0, 0, 1'b1);
    endtask

    initial begin
        rst_n      = 1'b0;
        play       = 1'b0;
        song       = '0;
        lfsr_state = 32'h8be5;
        cur_song   = '0;
        cur_idx    = '0;
        mismatches = 0;
        failures   = 0;
        $readmemh("song_rom.hex", model);
        // The longest note bounds every note that the tests play.
        max_beats = 1;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            if (int'(model[i][5:0]) > max_beats) begin
                max_beats = int'(model[i][5:0]);
            end
        end
        timeout_cycles = NOTES_PLAYED * (max_beats * int'(BEAT_CYCLES) + 2) + 100;
        apply_reset();
        check_idle_after_reset();
        check_song_notes();
        check_pause();
        check_song_wrap();
        check_audio_tones();
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- music_player.sv
`default_nettype none
`timescale 1ns/1ps

// Tone sequencer top.
// The reader fetches notes from the song ROM, the player times them and the
// synthesizer turns the sounding note into a one-bit square wave.
module music_player import music_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        play,
    input  song_sel_t  song,
    output note_t      note,
    output duration_t  duration,
    output logic       new_note,
    output logic       note_done,
    output logic       song_done,
    output logic       audio
);

    logic  sounding;
    note_t sound_note;

    song_reader reader_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .song      (song),
        .note_done (note_done),
        .new_note  (new_note),
        .note      (note),
        .duration  (duration),
        .song_done (song_done)
    );

    note_player player_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .play       (play),
        .new_note   (new_note),
        .note       (note),
        .duration   (duration),
        .note_done  (note_done),
        .sounding   (sounding),
        .sound_note (sound_note)
    );

    square_synth synth_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sounding (sounding),
        .note     (sound_note),
        .audio    (audio)
    );

endmodule

`default_nettype wire

//--- square_synth.sv
`default_nettype none
`timescale 1ns/1ps

// Square-wave tone generator.
// The pitch code is split into octave and semitone. The semitone picks a half
// period from the table and the octave divides it by a power of two.
module square_synth import music_pkg::*, synth_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    sounding,
    input  note_t  note,
    output logic   audio
);

    logic [2:0]   octave;
    logic [3:0]   semitone;
    half_period_t half_period;
    half_period_t phase_cnt;
    logic         tone;
    logic         active;

    // Divide (note - 1) by 12 with five conditional subtractions.
    // Code 63 is the largest, which gives octave 5 and semitone 2.
    always_comb begin
        logic [5:0] remain;
        remain = note - 6'd1;
        octave = '0;
        for (int i = 0; i < 5; i++) begin
            if (remain >= 6'd12) begin
                remain = remain - 6'd12;
                octave = octave + 3'd1;
            end
        end
        semitone = remain[3:0];
    end

    assign half_period = SEMITONE_HALF[semitone] >> octave;

    // Rests and the gaps between notes stay silent.
    assign active = sounding && (note != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_cnt <= '0;
            tone      <= 1'b0;
        end else if (!active) begin
            phase_cnt <= '0;
            tone      <= 1'b0;
        end else if (phase_cnt == half_period - 16'd1) begin
            // One half period has passed, so flip the wave.
            phase_cnt <= '0;
            tone      <= ~tone;
        end else begin
            phase_cnt <= phase_cnt + 16'd1;
        end
    end

    // The gate drops the output in the same cycle that the note stops.
    assign audio = tone & active;

endmodule

`default_nettype wire

//--- note_player.sv
`default_nettype none
`timescale 1ns/1ps

// Times one note in beats of BEAT_CYCLES clocks.
// The note and its length are taken on new_note, and note_done pulses when
// the last beat has run out. Counting stops while play is low.
module note_player import music_pkg::*, synth_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        play,
    input  wire        new_note,
    input  note_t      note,
    input  duration_t  duration,
    output logic       note_done,
    output logic       sounding,
    output note_t      sound_note
);

    beat_cnt_t beat_cnt;
    duration_t beats_left;
    logic      beat_end;
    logic      last_beat;

    assign beat_end  = (beat_cnt == BEAT_CYCLES - 8'd1);
    assign last_beat = (beats_left == 6'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            beats_left <= '0;
            sounding   <= 1'b0;
            note_done  <= 1'b0;
        end else begin
            note_done <= 1'b0;
            if (new_note) begin
                // The load cycle is the first clock of the first beat.
                // That puts note_done exactly duration*BEAT_CYCLES clocks later.
                beat_cnt   <= 8'd1;
                beats_left <= (duration == '0) ? 6'd1 : duration;
                sounding   <= 1'b1;
            end else if (sounding && play) begin
                if (beat_end) begin
                    beat_cnt   <= '0;
                    beats_left <= beats_left - 6'd1;
                    // The note stops at the end of its final beat.
                    if (last_beat) begin
                        sounding  <= 1'b0;
                        note_done <= 1'b1;
                    end
                end else begin
                    beat_cnt <= beat_cnt + 8'd1;
                end
            end
        end
    end

    // Pitch of the note being played. Only read while sounding is high.
    always_ff @(posedge clk) begin
        if (new_note) begin
            sound_note <= note;
        end
    end

endmodule

`default_nettype wire

//--- song_reader.sv
`default_nettype none
`timescale 1ns/1ps

// Steps through one song of the ROM and hands each note to the player.
// A note is presented with a one-clock new_note pulse and then held until the
// next one. The reader then waits for note_done before it moves on.
module song_reader import music_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        play,
    input  song_sel_t  song,
    input  wire        note_done,
    output logic       new_note,
    output note_t      note,
    output duration_t  duration,
    output logic       song_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PRESENT,
        ST_WAIT_DONE
    } state_t;

    state_t    state;
    state_t    state_next;
    note_idx_t idx;
    note_idx_t idx_next;
    logic      advance;
    rom_addr_t rom_addr;
    rom_word_t rom_data;

    // The index moves on only when a note ends with play still high.
    // Past the last note it wraps to 0 through the natural 5-bit overflow.
    assign advance  = (state == ST_WAIT_DONE) && note_done && play;
    assign idx_next = advance ? idx + 5'd1 : idx;

    // The ROM is addressed with the upcoming index, so the word is already
    // on rom_data during the fetch state.
    assign rom_addr = {song, idx_next};

    // End of song is flagged in the same cycle as the last note_done.
    assign song_done = (state == ST_WAIT_DONE) && note_done && (idx == LAST_NOTE);

    song_rom rom_i (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    always_comb begin
        state_next = state;
        case (state)
            // Wait here while paused.
            ST_IDLE:      if (play) state_next = ST_FETCH;
            // The ROM read for the current index happens in this cycle.
            ST_FETCH:     state_next = ST_PRESENT;
            // The note is on the outputs and new_note is high.
            ST_PRESENT:   state_next = ST_WAIT_DONE;
            // A note that ends while paused sends the reader back to idle.
            // The index is kept, so the same note plays again on resume.
            ST_WAIT_DONE: begin
                if (note_done) begin
                    state_next = play ? ST_FETCH : ST_IDLE;
                end
            end
            default:      state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            idx      <= '0;
            new_note <= 1'b0;
            note     <= '0;
            duration <= '0;
        end else begin
            state    <= state_next;
            idx      <= idx_next;
            // The word read in fetch is captured so that it is valid in present.
            new_note <= (state == ST_FETCH);
            if (state == ST_FETCH) begin
                note     <= rom_data[11:6];
                duration <= rom_data[5:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- song_rom.sv
`default_nettype none
`timescale 1ns/1ps

// Song storage. Four songs of 32 words each, stored song after song.
// The read is registered, so data follows addr by one clock.
module song_rom import music_pkg::*; (
    input  wire        clk,
    input  rom_addr_t  addr,
    output rom_word_t  data
);

    rom_word_t mem [0:ROM_DEPTH-1];

    // The image is loaded once at elaboration.
    initial begin
        $readmemh("song_rom.hex", mem);
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

`default_nettype wire

//--- synth_pkg.sv
`default_nettype none

// Sound-side definitions for the beat timing and the square-wave pitch table.
package synth_pkg;

    // Counter type for the clocks within one beat.
    typedef logic [7:0] beat_cnt_t;

    // A half period of the square wave, in clocks.
    typedef logic [15:0] half_period_t;

    // Clocks per beat. Kept very short so that whole songs simulate quickly.
    localparam beat_cnt_t BEAT_CYCLES = 8'd4;

    // Half periods for the twelve semitones of octave 0, from C up to B.
    // Each step is close to the twelfth root of two. Higher octaves shift
    // these values right by the octave number.
    localparam half_period_t SEMITONE_HALF [0:11] = '{
        16'd128, 16'd121, 16'd114, 16'd108,
        16'd102, 16'd96,  16'd91,  16'd85,
        16'd81,  16'd76,  16'd72,  16'd68
    };

endpackage

`default_nettype wire

//--- music_pkg.sv
`default_nettype none

// Types and sizes that describe the score: songs, notes, durations and the ROM
// that holds them.
package music_pkg;

    // Song number. It selects one quarter of the song ROM.
    typedef logic [1:0] song_sel_t;

    // Position of a note within one song.
    typedef logic [4:0] note_idx_t;

    // ROM address, made of the song number above the note index.
    typedef logic [6:0] rom_addr_t;

    // Pitch code. Code 0 is a rest and codes 1 to 63 are octave*12+semitone+1.
    typedef logic [5:0] note_t;

    // Note length in beats. A length of 0 plays as a single beat.
    typedef logic [5:0] duration_t;

    // One ROM word holds the note in bits 11:6 and the duration in bits 5:0.
    typedef logic [11:0] rom_word_t;

    localparam note_idx_t LAST_NOTE  = 5'd31;
    localparam int        SONG_COUNT = 4;
    localparam int        ROM_DEPTH  = SONG_COUNT * (int'(LAST_NOTE) + 1);

endpackage

`default_nettype wire
